// File: verilog.f
+incdir+.
usiBusPkg.sv
mcbCmdPkg.sv
microControllerUnit.sv
microControllerCsr.sv
usiSlaveRegs.sv
microControllerBlock.sv
usiSubsystem.sv
tbUsiSubsystem.sv

// File: Makefile
TOP := tbUsiSubsystem

.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o simv
	-./obj_dir/simv > sim.log 2>&1
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tbVectors.svh
// Command table for the subsystem testbench, included inside the testbench module
// Each entry is one host command with its expected status and read data
// Expected data of write-count reads is computed by the testbench, the table holds zero
`ifndef tbVectorsSvh
`define tbVectorsSvh

typedef struct packed {
	mcbCmdPkg::mcbCmd    cmd;
	mcbCmdPkg::mcbStatus expStatus;
	usiBusPkg::usiData   expData;
} tbVec;

// Short names for the table
localparam mcbCmdPkg::mcbOp     cWr  = mcbCmdPkg::opWrite;
localparam mcbCmdPkg::mcbOp     cRd  = mcbCmdPkg::opRead;
localparam mcbCmdPkg::mcbStatus cOk  = mcbCmdPkg::stOk;
localparam mcbCmdPkg::mcbStatus cErr = mcbCmdPkg::stDecodeErr;

localparam int cNumVec = 33;

localparam tbVec cVectors [cNumVec] = '{
	// Local scratch, read-only write count, ignored middle address bits
	'{'{cWr, 16'h0000, 32'hA5A5_0001}, cOk, 32'h0},
	'{'{cRd, 16'h0000, 32'h0}, cOk, 32'hA5A5_0001},
	'{'{cWr, 16'h0001, 32'hDEAD_BEEF}, cOk, 32'h0},
	'{'{cRd, 16'h0001, 32'h0}, cOk, 32'h0},
	'{'{cRd, 16'h0FF0, 32'h0}, cOk, 32'hA5A5_0001},
	// Slow slave, burst then immediate reads
	'{'{cWr, 16'h2002, 32'h1111_0002}, cOk, 32'h0},
	'{'{cWr, 16'h2003, 32'h1111_0003}, cOk, 32'h0},
	'{'{cWr, 16'h2002, 32'h2222_0002}, cOk, 32'h0},
	'{'{cRd, 16'h2002, 32'h0}, cOk, 32'h2222_0002},
	'{'{cRd, 16'h2003, 32'h0}, cOk, 32'h1111_0003},
	// Five writes, more than both credit pools together
	'{'{cWr, 16'h2008, 32'hC0DE_0008}, cOk, 32'h0},
	'{'{cWr, 16'h2009, 32'hC0DE_0009}, cOk, 32'h0},
	'{'{cWr, 16'h200A, 32'hC0DE_000A}, cOk, 32'h0},
	'{'{cWr, 16'h200B, 32'hC0DE_000B}, cOk, 32'h0},
	'{'{cWr, 16'h200C, 32'hC0DE_000C}, cOk, 32'h0},
	'{'{cRd, 16'h2008, 32'h0}, cOk, 32'hC0DE_0008},
	'{'{cRd, 16'h2009, 32'h0}, cOk, 32'hC0DE_0009},
	'{'{cRd, 16'h200A, 32'h0}, cOk, 32'hC0DE_000A},
	'{'{cRd, 16'h200B, 32'h0}, cOk, 32'hC0DE_000B},
	'{'{cRd, 16'h200C, 32'h0}, cOk, 32'hC0DE_000C},
	// Decode errors must leave index 5 of both slaves alone
	'{'{cWr, 16'h1005, 32'h5555_0005}, cOk, 32'h0},
	'{'{cWr, 16'h2005, 32'h6666_0005}, cOk, 32'h0},
	'{'{cWr, 16'h3005, 32'hBAD0_0005}, cErr, 32'h0},
	'{'{cWr, 16'hF0A5, 32'hBAD1_0005}, cErr, 32'h0},
	'{'{cRd, 16'h7005, 32'h0}, cErr, 32'h0},
	'{'{cRd, 16'h1005, 32'h0}, cOk, 32'h5555_0005},
	'{'{cRd, 16'h2005, 32'h0}, cOk, 32'h6666_0005},
	// Interleaved slaves, same index
	'{'{cWr, 16'h1007, 32'h0000_0071}, cOk, 32'h0},
	'{'{cWr, 16'h2007, 32'h0000_0072}, cOk, 32'h0},
	'{'{cWr, 16'h1007, 32'h0000_0073}, cOk, 32'h0},
	'{'{cRd, 16'h2007, 32'h0}, cOk, 32'h0000_0072},
	'{'{cRd, 16'h1007, 32'h0}, cOk, 32'h0000_0073},
	// Final write count
	'{'{cRd, 16'h0001, 32'h0}, cOk, 32'h0}
};

`endif

// File: tbUsiSubsystem.sv
// Testbench for the Usi subsystem, slow slave drains slower than commands arrive
// Host side keeps its own credit count, responses are checked in command order
`default_nettype none

module tbUsiSubsystem;
	timeunit 1ns;
	timeprecision 1ps;

	`include "tbVectors.svh"

	localparam int cClkPeriod   = 40;
	localparam int cResetCycles = 16;
	localparam int cHostCredits = 2;

	logic             sysClk;
	logic             rst;
	mcbCmdPkg::mcbCmd cmd;
	logic             cmdValid;
	logic             cmdCredit;
	mcbCmdPkg::mcbRsp rsp;
	logic             rspValid;
	logic [31:0]      lfsrState;
	int               hostCredits;

	// Slave 1 drains far slower than one command per four cycles, so its queue fills
	usiSubsystem #(
		.pHostCredits  (cHostCredits),
		.pSlaveCredits (2),
		.pDrainDelay0  (1),
		.pDrainDelay1  (16)
	) uut (
		.sysClk    (sysClk),
		.rst       (rst),
		.cmd       (cmd),
		.cmdValid  (cmdValid),
		.cmdCredit (cmdCredit),
		.rsp       (rsp),
		.rspValid  (rspValid)
	);

	initial sysClk = 1'b0;
	always #(cClkPeriod / 2) sysClk = ~sysClk;

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic abortRun();
		$display("SIMULATION FAILED");
		$fatal(1, "Run aborted");
	endtask

	task automatic checkStatus(input mcbCmdPkg::mcbStatus got,
		input mcbCmdPkg::mcbStatus exp, input int idx);
		if (got !== exp) begin
			$display("ERR %0t: vector %0d status %s, expected %s",
				$time, idx, got.name(), exp.name());
			abortRun();
		end
	endtask

	task automatic checkData(input usiBusPkg::usiData got,
		input usiBusPkg::usiData exp, input int idx);
		if (got !== exp) begin
			$display("ERR %0t: vector %0d data %h, expected %h", $time, idx, got, exp);
			abortRun();
		end
	endtask

	task automatic checkCredits(input int credits);
		if (credits > cHostCredits) begin
			$display("Host credit overflow: more credits returned than commands sent");
			abortRun();
		end
	endtask

	// Galois LFSR, one step per bit
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
	endfunction

	// 0 to 3 idle cycles from two LFSR bits
	task automatic drawGap(output int gap);
		logic [1:0] bits;
		bits = '0;
		for (int b = 0; b < 2; b++) begin
			lfsrState = lfsrStep(lfsrState);
			bits      = {bits[0], lfsrState[0]};
		end
		gap = int'(bits);
	endtask

	// Address map decoded straight from the bit fields
	function automatic logic isCountRead(input mcbCmdPkg::mcbCmd c);
		return (c.op == mcbCmdPkg::opRead) && (c.adrs[15:12] == mcbCmdPkg::blkLocal) &&
			(c.adrs[3:0] == mcbCmdPkg::regWrCount);
	endfunction

	function automatic logic isSlaveWrite(input mcbCmdPkg::mcbCmd c);
		return (c.op == mcbCmdPkg::opWrite) && ((c.adrs[15:12] == mcbCmdPkg::blkSlave0) ||
			(c.adrs[15:12] == mcbCmdPkg::blkSlave1));
	endfunction

	// ------------------------------
	// Reset and credit-aware driver
	// ------------------------------
	initial begin : driveStim
		int idx;
		int gap;
		rst         = 1'b1;
		cmd         = '0;
		cmdValid    = 1'b0;
		lfsrState   = 32'h55e;
		idx         = 0;
		hostCredits = cHostCredits;
		repeat (cResetCycles) @(posedge sysClk);
		rst <= 1'b0;
		drawGap(gap);
		while (idx < cNumVec) begin
			@(posedge sysClk);
			// Credit pulse of the cycle that just ended
			if (cmdCredit === 1'b1) begin
				hostCredits++;
			end
			checkCredits(hostCredits);
			if (gap > 0) begin
				cmdValid <= 1'b0;
				gap--;
			end else if (hostCredits > 0) begin
				cmd      <= cVectors[idx].cmd;
				cmdValid <= 1'b1;
				hostCredits--;
				idx++;
				drawGap(gap);
			end else begin
				cmdValid <= 1'b0;
			end
		end
		// Keep watching returned credits until the end
		forever begin
			@(posedge sysClk);
			cmdValid <= 1'b0;
			if (cmdCredit === 1'b1) begin
				hostCredits++;
			end
			checkCredits(hostCredits);
		end
	end

	// ------------------------------
	// Response checker
	// ------------------------------
	initial begin : rspCheck
		int                rspIdx;
		int                slaveWrites;
		tbVec              vec;
		usiBusPkg::usiData expData;
		rspIdx      = 0;
		slaveWrites = 0;
		while (rspIdx < cNumVec) begin
			@(posedge sysClk);
			if (rspValid === 1'b1) begin
				vec     = cVectors[rspIdx];
				expData = vec.expData;
				// Count register tracks slave writes answered so far
				if (isCountRead(vec.cmd)) begin
					expData = usiBusPkg::usiData'(slaveWrites);
				end
				checkStatus(rsp.status, vec.expStatus, rspIdx);
				checkData(rsp.data, expData, rspIdx);
				if (isSlaveWrite(vec.cmd)) begin
					slaveWrites++;
				end
				rspIdx++;
			end
		end
		// Every queued command was popped, so all credits are back
		@(negedge sysClk);
		if (hostCredits != cHostCredits) begin
			$display("Host credit underflow: only %0d of %0d command credits came back",
				hostCredits, cHostCredits);
			abortRun();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

	// Watchdog
	initial begin
		repeat (cResetCycles + cNumVec * 100) @(posedge sysClk);
		$display("Timeout: not every command received its response in time");
		abortRun();
	end

endmodule

`default_nettype wire

// File: usiSubsystem.sv
// Top level, master block with a fast and a slow register slave
// Host starts with pHostCredits command credits
`default_nettype none

module usiSubsystem #(
	parameter int pHostCredits  = 2,
	parameter int pSlaveCredits = 2,
	parameter int pDrainDelay0  = 1,
	parameter int pDrainDelay1  = 3
) (
	input  wire logic             sysClk,
	input  wire logic             rst,
	input  wire mcbCmdPkg::mcbCmd cmd,
	input  wire logic             cmdValid,
	output logic                  cmdCredit,
	output mcbCmdPkg::mcbRsp      rsp,
	output logic                  rspValid
);

	usiBusPkg::usiWrReq wrReq0;
	usiBusPkg::usiWrReq wrReq1;
	logic               wrValid0;
	logic               wrValid1;
	logic               wrCredit0;
	logic               wrCredit1;
	logic               rdValid0;
	logic               rdValid1;
	usiBusPkg::usiRdRet rdRet0;
	usiBusPkg::usiRdRet rdRet1;
	usiBusPkg::usiAdrs  rdAdrs;

	microControllerBlock #(
		.pHostCredits  (pHostCredits),
		.pSlaveCredits (pSlaveCredits)
	) master (
		.sysClk    (sysClk),
		.rst       (rst),
		.cmd       (cmd),
		.cmdValid  (cmdValid),
		.cmdCredit (cmdCredit),
		.rsp       (rsp),
		.rspValid  (rspValid),
		.wrReq0    (wrReq0),
		.wrValid0  (wrValid0),
		.wrCredit0 (wrCredit0),
		.rdValid0  (rdValid0),
		.rdRet0    (rdRet0),
		.wrReq1    (wrReq1),
		.wrValid1  (wrValid1),
		.wrCredit1 (wrCredit1),
		.rdValid1  (rdValid1),
		.rdRet1    (rdRet1),
		.rdAdrs    (rdAdrs)
	);

	// Block select 1, fast drain
	usiSlaveRegs #(
		.pSlaveCredits (pSlaveCredits),
		.pDrainDelay   (pDrainDelay0)
	) slave0 (
		.sysClk   (sysClk),
		.rst      (rst),
		.wrReq    (wrReq0),
		.wrValid  (wrValid0),
		.wrCredit (wrCredit0),
		.rdAdrs   (rdAdrs),
		.rdValid  (rdValid0),
		.rdRet    (rdRet0)
	);

	// Block select 2, slow drain
	usiSlaveRegs #(
		.pSlaveCredits (pSlaveCredits),
		.pDrainDelay   (pDrainDelay1)
	) slave1 (
		.sysClk   (sysClk),
		.rst      (rst),
		.wrReq    (wrReq1),
		.wrValid  (wrValid1),
		.wrCredit (wrCredit1),
		.rdAdrs   (rdAdrs),
		.rdValid  (rdValid1),
		.rdRet    (rdRet1)
	);

endmodule

`default_nettype wire

// File: microControllerBlock.sv
// Master side of the Usi bus, two slave slots
`default_nettype none

module microControllerBlock #(
	parameter int pHostCredits  = 2,
	parameter int pSlaveCredits = 2
) (
	input  wire logic               sysClk,
	input  wire logic               rst,
	// Host side
	input  wire mcbCmdPkg::mcbCmd   cmd,
	input  wire logic               cmdValid,
	output logic                    cmdCredit,
	output mcbCmdPkg::mcbRsp        rsp,
	output logic                    rspValid,
	// Slave 0
	output usiBusPkg::usiWrReq      wrReq0,
	output logic                    wrValid0,
	input  wire logic               wrCredit0,
	output logic                    rdValid0,
	input  wire usiBusPkg::usiRdRet rdRet0,
	// Slave 1
	output usiBusPkg::usiWrReq      wrReq1,
	output logic                    wrValid1,
	input  wire logic               wrCredit1,
	output logic                    rdValid1,
	input  wire usiBusPkg::usiRdRet rdRet1,
	// Read address, common to both slots
	output usiBusPkg::usiAdrs       rdAdrs
);

	mcbCmdPkg::mcbCmd req;
	logic             reqValid;
	logic             done;
	mcbCmdPkg::mcbRsp doneRsp;

	// ------------------------------
	// Sequencer
	// ------------------------------
	microControllerUnit #(
		.pHostCredits (pHostCredits)
	) unit (
		.sysClk    (sysClk),
		.rst       (rst),
		.cmd       (cmd),
		.cmdValid  (cmdValid),
		.cmdCredit (cmdCredit),
		.rsp       (rsp),
		.rspValid  (rspValid),
		.req       (req),
		.reqValid  (reqValid),
		.done      (done),
		.doneRsp   (doneRsp)
	);

	// ------------------------------
	// CSR and bus master
	// ------------------------------
	microControllerCsr #(
		.pSlaveCredits (pSlaveCredits)
	) csr (
		.sysClk    (sysClk),
		.rst       (rst),
		.req       (req),
		.reqValid  (reqValid),
		.done      (done),
		.doneRsp   (doneRsp),
		.wrReq0    (wrReq0),
		.wrReq1    (wrReq1),
		.wrValid0  (wrValid0),
		.wrValid1  (wrValid1),
		.wrCredit0 (wrCredit0),
		.wrCredit1 (wrCredit1),
		.rdAdrs    (rdAdrs),
		.rdValid0  (rdValid0),
		.rdValid1  (rdValid1),
		.rdRet0    (rdRet0),
		.rdRet1    (rdRet1)
	);

endmodule

`default_nettype wire

// File: usiSlaveRegs.sv
// Sixteen register slave, writes drain at one per pDrainDelay cycles
// Sender must hold a credit per write, reads wait for an empty queue
`default_nettype none

module usiSlaveRegs #(
	parameter int pSlaveCredits = 2,
	parameter int pDrainDelay   = 1
) (
	input  wire logic               sysClk,
	input  wire logic               rst,
	input  wire usiBusPkg::usiWrReq wrReq,
	input  wire logic               wrValid,
	output logic                    wrCredit,
	input  wire usiBusPkg::usiAdrs  rdAdrs,
	input  wire logic               rdValid,
	output usiBusPkg::usiRdRet      rdRet
);

	localparam int cPtrW = (pSlaveCredits > 1) ? $clog2(pSlaveCredits) : 1;
	localparam int cCntW = $clog2(pSlaveCredits + 1);
	localparam int cDlyW = (pDrainDelay > 1) ? $clog2(pDrainDelay) : 1;

	usiBusPkg::usiWrReq  fifoMem [pSlaveCredits];
	usiBusPkg::usiData   regFile [16];
	usiBusPkg::usiWrReq  head;
	logic [cPtrW-1:0]    wrPtr;
	logic [cPtrW-1:0]    rdPtr;
	logic [cCntW-1:0]    fifoCnt;
	logic [cDlyW-1:0]    drainCnt;
	logic                pop;
	logic                wantRd;
	logic                rdGo;
	logic                rdPend;
	logic                rdOut;
	usiBusPkg::usiRegIdx pendIdx;
	usiBusPkg::usiRegIdx curIdx;
	usiBusPkg::usiData   rdData;

	function automatic logic [cPtrW-1:0] nextPtr(input logic [cPtrW-1:0] ptr);
		return (ptr == cPtrW'(pSlaveCredits - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// ------------------------------
	// Write queue and drain pacing
	// ------------------------------
	assign head     = fifoMem[rdPtr];
	assign pop      = (fifoCnt != '0) && (drainCnt == cDlyW'(pDrainDelay - 1));
	assign wrCredit = pop;

	always_ff @(posedge sysClk) begin
		if (wrValid) begin
			fifoMem[wrPtr] <= wrReq;
		end
	end

	always_ff @(posedge sysClk) begin
		if (rst) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			fifoCnt  <= '0;
			drainCnt <= '0;
			for (int i = 0; i < 16; i++) begin
				regFile[i] <= '0;
			end
		end else begin
			if (wrValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			// Pace counter restarts at every pop and while empty
			if (pop || fifoCnt == '0) begin
				drainCnt <= '0;
			end else begin
				drainCnt <= drainCnt + 1'b1;
			end
			if (pop) begin
				rdPtr                                   <= nextPtr(rdPtr);
				regFile[usiBusPkg::regIdx(head.adrs)] <= head.data;
			end
			if (wrValid && !pop) begin
				fifoCnt <= fifoCnt + 1'b1;
			end else if (!wrValid && pop) begin
				fifoCnt <= fifoCnt - 1'b1;
			end
		end
	end

	// ------------------------------
	// Read path
	// ------------------------------
	// A read waits until every queued write has landed
	assign wantRd = rdValid | rdPend;
	assign curIdx = rdValid ? usiBusPkg::regIdx(rdAdrs) : pendIdx;
	assign rdGo   = wantRd && (fifoCnt == '0);

	always_ff @(posedge sysClk) begin
		if (rst) begin
			rdPend <= 1'b0;
			rdOut  <= 1'b0;
		end else begin
			rdPend <= wantRd && !rdGo;
			rdOut  <= rdGo;
		end
	end

	always_ff @(posedge sysClk) begin
		pendIdx <= curIdx;
		if (rdGo) begin
			rdData <= regFile[curIdx];
		end
	end

	assign rdRet.data  = rdData;
	assign rdRet.valid = rdOut;

endmodule

`default_nettype wire

// File: microControllerCsr.sv
// Local registers, block decode and slave access for the master block
// Accepts one request at a time, the next reqValid only after done
`default_nettype none

module microControllerCsr #(
	parameter int pSlaveCredits = 2
) (
	input  wire logic               sysClk,
	input  wire logic               rst,
	input  wire mcbCmdPkg::mcbCmd   req,
	input  wire logic               reqValid,
	output logic                    done,
	output mcbCmdPkg::mcbRsp        doneRsp,
	output usiBusPkg::usiWrReq      wrReq0,
	output usiBusPkg::usiWrReq      wrReq1,
	output logic                    wrValid0,
	output logic                    wrValid1,
	input  wire logic               wrCredit0,
	input  wire logic               wrCredit1,
	output usiBusPkg::usiAdrs       rdAdrs,
	output logic                    rdValid0,
	output logic                    rdValid1,
	input  wire usiBusPkg::usiRdRet rdRet0,
	input  wire usiBusPkg::usiRdRet rdRet1
);

	localparam int cCntW = $clog2(pSlaveCredits + 1);

	typedef enum logic [1:0] {
		idle,
		wrStall,
		rdWait
	} csrState;

	csrState              state;
	mcbCmdPkg::mcbCmd     cur;
	mcbCmdPkg::mcbCmd     actCmd;
	usiBusPkg::usiBlockSel actBlk;
	usiBusPkg::usiRegIdx  actIdx;
	logic                 isSlave;
	logic                 slvSel;
	logic                 start;
	logic                 sendWr;
	logic [cCntW-1:0]     creditCnt [2];
	logic [1:0]           wrCreditVec;
	logic [1:0]           wrValidQ;
	logic [1:0]           rdValidQ;
	usiBusPkg::usiWrReq   wrReqQ;
	usiBusPkg::usiData    scratch;
	usiBusPkg::usiData    wrCount;
	usiBusPkg::usiData    localRd;
	logic                 retValid;
	usiBusPkg::usiData    retData;

	// ------------------------------
	// Decode
	// ------------------------------
	// In idle the incoming request is decoded directly
	assign actCmd  = (state == idle) ? req : cur;
	assign actBlk  = usiBusPkg::blockSel(actCmd.adrs);
	assign actIdx  = usiBusPkg::regIdx(actCmd.adrs);
	assign isSlave = (actBlk == mcbCmdPkg::blkSlave0) || (actBlk == mcbCmdPkg::blkSlave1);
	assign slvSel  = (actBlk == mcbCmdPkg::blkSlave1);
	assign start   = (state == idle) && reqValid;
	// Write goes out as soon as the target slave has a credit
	assign sendWr  = (start || state == wrStall) && isSlave &&
		(actCmd.op == mcbCmdPkg::opWrite) && (creditCnt[slvSel] != '0);

	// Local read mux, unknown indices read zero
	always_comb begin
		localRd = '0;
		if (actCmd.op == mcbCmdPkg::opRead) begin
			if (actIdx == mcbCmdPkg::regScratch) begin
				localRd = scratch;
			end else if (actIdx == mcbCmdPkg::regWrCount) begin
				localRd = wrCount;
			end
		end
	end

	// Return merge, only the addressed slave answers
	assign retValid = rdRet0.valid | rdRet1.valid;
	assign retData  = rdRet1.valid ? rdRet1.data : rdRet0.data;

	// ------------------------------
	// Per-slave write credits
	// ------------------------------
	assign wrCreditVec = {wrCredit1, wrCredit0};

	for (genvar i = 0; i < 2; i++) begin : gCredit
		always_ff @(posedge sysClk) begin
			if (rst) begin
				creditCnt[i] <= cCntW'(pSlaveCredits);
			end else if (wrCreditVec[i] && !(sendWr && slvSel == 1'(i))) begin
				creditCnt[i] <= creditCnt[i] + 1'b1;
			end else if (!wrCreditVec[i] && sendWr && slvSel == 1'(i)) begin
				creditCnt[i] <= creditCnt[i] - 1'b1;
			end
		end
	end

	// ------------------------------
	// Control FSM
	// ------------------------------
	always_ff @(posedge sysClk) begin
		if (rst) begin
			state    <= idle;
			done     <= 1'b0;
			wrValidQ <= '0;
			rdValidQ <= '0;
			scratch  <= '0;
			wrCount  <= '0;
		end else begin
			done     <= 1'b0;
			wrValidQ <= '0;
			rdValidQ <= '0;
			// Slave write and its done share one cycle
			if (sendWr) begin
				wrValidQ[slvSel] <= 1'b1;
				wrCount          <= wrCount + 1'b1;
				done             <= 1'b1;
			end
			case (state)
				idle: begin
					if (reqValid) begin
						if (actBlk == mcbCmdPkg::blkLocal) begin
							done <= 1'b1;
							// Write count is read only
							if (actCmd.op == mcbCmdPkg::opWrite &&
								actIdx == mcbCmdPkg::regScratch) begin
								scratch <= actCmd.data;
							end
						end else if (isSlave) begin
							if (actCmd.op == mcbCmdPkg::opRead) begin
								rdValidQ[slvSel] <= 1'b1;
								state            <= rdWait;
							end else if (!sendWr) begin
								state <= wrStall;
							end
						end else begin
							// Decode error, nothing forwarded
							done <= 1'b1;
						end
					end
				end
				wrStall: begin
					if (sendWr) begin
						state <= idle;
					end
				end
				rdWait: begin
					if (retValid) begin
						done  <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge sysClk) begin
		if (start) begin
			cur    <= req;
			rdAdrs <= req.adrs;
		end
		if (sendWr) begin
			wrReqQ  <= '{adrs: actCmd.adrs, data: actCmd.data};
			doneRsp <= '{status: mcbCmdPkg::stOk, data: '0};
		end else if (start && actBlk == mcbCmdPkg::blkLocal) begin
			doneRsp <= '{status: mcbCmdPkg::stOk, data: localRd};
		end else if (start && !isSlave) begin
			doneRsp <= '{status: mcbCmdPkg::stDecodeErr, data: '0};
		end else if (state == rdWait && retValid) begin
			doneRsp <= '{status: mcbCmdPkg::stOk, data: retData};
		end
	end

	// Shared write payload, per-slave strobes
	assign wrReq0   = wrReqQ;
	assign wrReq1   = wrReqQ;
	assign wrValid0 = wrValidQ[0];
	assign wrValid1 = wrValidQ[1];
	assign rdValid0 = rdValidQ[0];
	assign rdValid1 = rdValidQ[1];

endmodule

`default_nettype wire

// File: microControllerUnit.sv
// Command sequencer, one bus operation in flight at a time
// Host must respect credits, queue overflow is not detected here
`default_nettype none

module microControllerUnit #(
	parameter int pHostCredits = 2
) (
	input  wire logic              sysClk,
	input  wire logic              rst,
	input  wire mcbCmdPkg::mcbCmd  cmd,
	input  wire logic              cmdValid,
	output logic                   cmdCredit,
	output mcbCmdPkg::mcbRsp       rsp,
	output logic                   rspValid,
	output mcbCmdPkg::mcbCmd       req,
	output logic                   reqValid,
	input  wire logic              done,
	input  wire mcbCmdPkg::mcbRsp  doneRsp
);

	localparam int cPtrW = (pHostCredits > 1) ? $clog2(pHostCredits) : 1;
	localparam int cCntW = $clog2(pHostCredits + 1);

	// waitDone stands for the wait state
	typedef enum logic [1:0] {
		idle,
		issue,
		waitDone
	} unitState;

	unitState         state;
	mcbCmdPkg::mcbCmd fifoMem [pHostCredits];
	logic [cPtrW-1:0] wrPtr;
	logic [cPtrW-1:0] rdPtr;
	logic [cCntW-1:0] fifoCnt;
	logic             pop;

	// Wrap at queue depth, depth need not be a power of two
	function automatic logic [cPtrW-1:0] nextPtr(input logic [cPtrW-1:0] ptr);
		return (ptr == cPtrW'(pHostCredits - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// ------------------------------
	// Command queue
	// ------------------------------
	// Pop only when idle and the previous response has gone out
	assign pop       = (state == idle) && (fifoCnt != '0) && !rspValid;
	// Credit goes back with every pop
	assign cmdCredit = pop;

	always_ff @(posedge sysClk) begin
		if (cmdValid) begin
			fifoMem[wrPtr] <= cmd;
		end
	end

	always_ff @(posedge sysClk) begin
		if (rst) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			fifoCnt <= '0;
		end else begin
			if (cmdValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			if (cmdValid && !pop) begin
				fifoCnt <= fifoCnt + 1'b1;
			end else if (!cmdValid && pop) begin
				fifoCnt <= fifoCnt - 1'b1;
			end
		end
	end

	// ------------------------------
	// Sequencer
	// ------------------------------
	assign reqValid = (state == issue);

	always_ff @(posedge sysClk) begin
		if (rst) begin
			state    <= idle;
			rspValid <= 1'b0;
		end else begin
			rspValid <= 1'b0;
			case (state)
				idle: begin
					if (pop) begin
						state <= issue;
					end
				end
				// Request is held for exactly one cycle
				issue: state <= waitDone;
				waitDone: begin
					if (done) begin
						rspValid <= 1'b1;
						state    <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge sysClk) begin
		if (pop) begin
			req <= fifoMem[rdPtr];
		end
		if (state == waitDone && done) begin
			rsp <= doneRsp;
		end
	end

endmodule

`default_nettype wire

// File: mcbCmdPkg.sv
// Host command and response formats of the master block
// Address map constants for local registers and slave slots
`default_nettype none

package mcbCmdPkg;

	typedef enum logic {
		opWrite = 1'b0,
		opRead  = 1'b1
	} mcbOp;

	typedef enum logic {
		stOk        = 1'b0,
		stDecodeErr = 1'b1
	} mcbStatus;

	// Host command, 49 bits
	typedef struct packed {
		mcbOp             op;
		usiBusPkg::usiAdrs adrs;
		usiBusPkg::usiData data;
	} mcbCmd;

	// Response, data is zero unless a good read
	typedef struct packed {
		mcbStatus          status;
		usiBusPkg::usiData data;
	} mcbRsp;

	// Block select map
	localparam usiBusPkg::usiBlockSel blkLocal  = 4'd0;
	localparam usiBusPkg::usiBlockSel blkSlave0 = 4'd1;
	localparam usiBusPkg::usiBlockSel blkSlave1 = 4'd2;

	// Local register indices
	localparam usiBusPkg::usiRegIdx regScratch = 4'd0;
	localparam usiBusPkg::usiRegIdx regWrCount = 4'd1;

endpackage

`default_nettype wire

// File: usiBusPkg.sv
// Usi register bus types shared by master and slaves
// Address map is fixed: block select in [15:12], register index in [3:0]
`default_nettype none

package usiBusPkg;

	// ------------------------------
	// Plain vector widths
	// ------------------------------
	typedef logic [31:0] usiData;
	typedef logic [15:0] usiAdrs;
	typedef logic [3:0]  usiBlockSel;
	typedef logic [3:0]  usiRegIdx;

	// One write on the bus, 48 bits
	typedef struct packed {
		usiAdrs adrs;
		usiData data;
	} usiWrReq;

	// Read return, valid for exactly one cycle
	typedef struct packed {
		usiData data;
		logic   valid;
	} usiRdRet;

	// Block select field, bits 11..4 are don't care
	function automatic usiBlockSel blockSel(input usiAdrs adrs);
		return adrs[15:12];
	endfunction

	// Register index within a block
	function automatic usiRegIdx regIdx(input usiAdrs adrs);
		return adrs[3:0];
	endfunction

endpackage

`default_nettype wire
